// ==== icb_bridge_settings.svh ====
/* bus geometry and queue depth for the unaligned ICB bridge
   included by the package and by every bridge module */

`ifndef ICB_BRIDGE_SETTINGS_SVH
`define ICB_BRIDGE_SETTINGS_SVH

// ======================================================================
// bus widths
// ======================================================================

// byte address width on both ports
`define ICB_AW 32

// data width, fixed at one 32-bit word
// offset math below is byte-in-word, so this stays 32
`define ICB_DW 32

// burst length field, beats minus one, 8 beats max
`define ICB_LW 3

// ======================================================================
// queueing
// ======================================================================

// outstanding request FIFO entries, power of two
`define ICB_OUTS 8

`endif

// ==== icb_bridge_pkg.sv ====
/* channel payload structs and FSM encodings shared by the bridge blocks
   modules refer to these by scoped name */

`include "icb_bridge_settings.svh"

package icb_bridge_pkg;

  // ======================================================================
  // channel payloads
  // ======================================================================

  // upstream request, byte address plus beats minus one
  typedef struct packed {
    logic [`ICB_AW-1:0] addr;
    logic               read;
    logic [`ICB_LW-1:0] len;
  } icb_cmd_t;

  // upstream write beat, mask bit per byte lane
  typedef struct packed {
    logic [`ICB_DW-1:0]   wdata;
    logic [`ICB_DW/8-1:0] wmask;
  } icb_wbeat_t;

  // downstream command, always word aligned
  typedef struct packed {
    logic [`ICB_AW-1:0]   addr;
    logic                 read;
    logic [`ICB_DW-1:0]   wdata;
    logic [`ICB_DW/8-1:0] wmask;
  } icb_mcmd_t;

  // response payload, same shape on both sides
  typedef struct packed {
    logic [`ICB_DW-1:0] rdata;
    logic               err;
  } icb_rsp_t;

  // command sequencer states
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_FIRST, SEQ_BURST} seq_state_t;
  // response merger states
  typedef enum logic {RSP_IDLE, RSP_MERGE} rsp_state_t;

endpackage

// ==== icb_cmd_fifo.sv ====
/* outstanding request queue between the upstream command port and the sequencer
   head is read combinationally, entry retires on pop */

`timescale 1ns/100ps
`include "icb_bridge_settings.svh"

module icb_cmd_fifo (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push_valid,
  output logic                     push_ready,
  input  icb_bridge_pkg::icb_cmd_t push_cmd,
  output icb_bridge_pkg::icb_cmd_t head,
  output logic                     head_valid,
  input  logic                     pop
);

  localparam int DEPTH = `ICB_OUTS;
  localparam int PW    = $clog2(DEPTH);

  // storage, payload only
  icb_bridge_pkg::icb_cmd_t mem [DEPTH];

  // msb of each pointer is the wrap bit
  logic [PW:0] wr_ptr;
  logic [PW:0] rd_ptr;
  logic        full;
  logic        push;

  // same slot, opposite lap
  assign full       = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);
  assign head_valid = (wr_ptr != rd_ptr);
  assign push_ready = !full;
  assign push       = push_valid && push_ready;

  // head visible the cycle after the push
  assign head = mem[rd_ptr[PW-1:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      // sequencer only pops a valid head
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr[PW-1:0]] <= push_cmd;
  end

endmodule

// ==== icb_cmd_sequencer.sv ====
/* turns one queued request into word-aligned downstream command beats
   write beats are shifted into lanes, unaligned spill comes from a holding buffer */

`timescale 1ns/100ps
`include "icb_bridge_settings.svh"

module icb_cmd_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  icb_bridge_pkg::icb_cmd_t   head,
  input  logic                       head_valid,
  output logic                       pop,
  input  logic                       rsp_idle,
  output icb_bridge_pkg::icb_cmd_t   cur_cmd,
  output logic                       start,
  input  logic                       sa_w_valid,
  output logic                       sa_w_ready,
  input  icb_bridge_pkg::icb_wbeat_t sa_w,
  output logic                       m_cmd_valid,
  input  logic                       m_cmd_ready,
  output icb_bridge_pkg::icb_mcmd_t  m_cmd
);

  localparam int AW = `ICB_AW;
  localparam int DW = `ICB_DW;
  localparam int MW = `ICB_DW/8;
  localparam int LW = `ICB_LW;

  icb_bridge_pkg::seq_state_t state;

  // downstream beat index, one wider than len for the spill beat
  logic [LW:0]    beat_cnt;
  logic [LW:0]    last_idx;
  logic [1:0]     off;
  logic           unaligned;
  logic           last_beat;
  logic           spill;
  logic           fire;
  logic [AW-1:0]  base;
  // shift amounts, bits for data and lanes for mask
  logic [5:0]     lo_sh;
  logic [5:0]     hi_sh;
  logic [2:0]     lo_msh;
  logic [2:0]     hi_msh;
  logic [DW-1:0]  wdata_sh;
  logic [MW-1:0]  wmask_sh;
  // upper bytes pushed out of the previous upstream beat
  logic [DW-1:0]  wbuf_data;
  logic [MW-1:0]  wbuf_mask;

  // ======================================================================
  // request decode
  // ======================================================================

  assign off       = cur_cmd.addr[1:0];
  assign unaligned = (off != 2'b00);
  assign base      = {cur_cmd.addr[AW-1:2], 2'b00};
  // len+1 beats, one more when the span crosses into an extra word
  assign last_idx  = {1'b0, cur_cmd.len} + {{LW{1'b0}}, unaligned};
  assign last_beat = (beat_cnt == last_idx);
  // final beat of an unaligned write, no upstream data behind it
  assign spill     = !cur_cmd.read && unaligned && last_beat;

  assign lo_sh  = {1'b0, off, 3'b000};
  assign hi_sh  = 6'(DW) - lo_sh;
  assign lo_msh = {1'b0, off};
  assign hi_msh = 3'(MW) - lo_msh;

  // ======================================================================
  // handshakes
  // ======================================================================

  // next request waits until the merger drained the previous one
  assign pop   = (state == icb_bridge_pkg::SEQ_IDLE) && head_valid && rsp_idle;
  assign start = pop;

  assign m_cmd_valid = (state != icb_bridge_pkg::SEQ_IDLE) &&
                       (cur_cmd.read || spill || sa_w_valid);
  // write beat only taken together with the downstream beat
  assign sa_w_ready  = (state != icb_bridge_pkg::SEQ_IDLE) && !cur_cmd.read &&
                       !spill && m_cmd_ready;
  assign fire        = m_cmd_valid && m_cmd_ready;

  // ======================================================================
  // downstream payload
  // ======================================================================

  assign wdata_sh = sa_w.wdata << lo_sh;
  assign wmask_sh = sa_w.wmask << lo_msh;

  always_comb begin
    // word base stepped by four per beat
    m_cmd.addr  = base + AW'({beat_cnt, 2'b00});
    m_cmd.read  = cur_cmd.read;
    m_cmd.wdata = '0;
    m_cmd.wmask = '0;
    if (!cur_cmd.read) begin
      if (spill) begin
        m_cmd.wdata = wbuf_data;
        m_cmd.wmask = wbuf_mask;
      end else if (state == icb_bridge_pkg::SEQ_BURST) begin
        m_cmd.wdata = wdata_sh | wbuf_data;
        m_cmd.wmask = wmask_sh | wbuf_mask;
      end else begin
        // first beat, nothing carried in
        m_cmd.wdata = wdata_sh;
        m_cmd.wmask = wmask_sh;
      end
    end
  end

  // ======================================================================
  // FSM and beat counter
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= icb_bridge_pkg::SEQ_IDLE;
      beat_cnt <= '0;
      cur_cmd  <= '0;
    end else begin
      case (state)
        icb_bridge_pkg::SEQ_IDLE: begin
          if (pop) begin
            cur_cmd  <= head;
            beat_cnt <= '0;
            state    <= icb_bridge_pkg::SEQ_FIRST;
          end
        end
        icb_bridge_pkg::SEQ_FIRST, icb_bridge_pkg::SEQ_BURST: begin
          // stalled downstream freezes the address too
          if (fire) begin
            if (last_beat) begin
              state <= icb_bridge_pkg::SEQ_IDLE;
            end else begin
              state    <= icb_bridge_pkg::SEQ_BURST;
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= icb_bridge_pkg::SEQ_IDLE;
      endcase
    end
  end

  // carry the lanes that spill into the next word
  // aligned case shifts by a full word and leaves zeros
  always_ff @(posedge clk) begin
    if (fire && !cur_cmd.read && !spill) begin
      wbuf_data <= sa_w.wdata >> hi_sh;
      wbuf_mask <= sa_w.wmask >> hi_msh;
    end
  end

endmodule

// ==== icb_rsp_merger.sv ====
/* collects downstream responses of the active request and builds upstream ones
   realigns read words and folds write responses into a single reply */

`timescale 1ns/100ps
`include "icb_bridge_settings.svh"

module icb_rsp_merger (
  input  logic                     clk,
  input  logic                     rst_n,
  input  icb_bridge_pkg::icb_cmd_t cur_cmd,
  input  logic                     start,
  output logic                     rsp_idle,
  input  logic                     m_rsp_valid,
  output logic                     m_rsp_ready,
  input  icb_bridge_pkg::icb_rsp_t m_rsp,
  output logic                     sa_rsp_valid,
  input  logic                     sa_rsp_ready,
  output icb_bridge_pkg::icb_rsp_t sa_rsp
);

  localparam int DW = `ICB_DW;
  localparam int LW = `ICB_LW;

  icb_bridge_pkg::rsp_state_t state;

  // downstream responses seen so far
  logic [LW:0]   rsp_cnt;
  logic [LW:0]   last_idx;
  logic [1:0]    off;
  logic          unaligned;
  logic          last_rsp;
  logic          fwd;
  logic          xfer;
  logic [5:0]    lo_sh;
  logic [5:0]    hi_sh;
  // previous downstream read word
  logic [DW-1:0] rbuf;
  // sticky write error
  logic          err_acc;

  // ======================================================================
  // expected response count
  // ======================================================================

  assign off       = cur_cmd.addr[1:0];
  assign unaligned = (off != 2'b00);
  assign last_idx  = {1'b0, cur_cmd.len} + {{LW{1'b0}}, unaligned};
  assign last_rsp  = (rsp_cnt == last_idx);
  assign lo_sh     = {1'b0, off, 3'b000};
  assign hi_sh     = 6'(DW) - lo_sh;

  // reads: only the leading word of an unaligned burst is swallowed
  // writes: only the final response goes up
  assign fwd = cur_cmd.read ? !(unaligned && (rsp_cnt == '0)) : last_rsp;

  // ======================================================================
  // upstream side
  // ======================================================================

  assign rsp_idle     = (state == icb_bridge_pkg::RSP_IDLE);
  assign sa_rsp_valid = (state == icb_bridge_pkg::RSP_MERGE) && m_rsp_valid && fwd;
  // absorbed beats never wait on upstream
  assign m_rsp_ready  = ((state == icb_bridge_pkg::RSP_MERGE) && fwd) ? sa_rsp_ready : 1'b1;
  assign xfer         = m_rsp_valid && m_rsp_ready;

  always_comb begin
    sa_rsp.rdata = '0;
    sa_rsp.err   = m_rsp.err;
    if (cur_cmd.read) begin
      // upper bytes of the older word, lower bytes of this one
      if (unaligned) begin
        sa_rsp.rdata = (rbuf >> lo_sh) | (m_rsp.rdata << hi_sh);
      end else begin
        sa_rsp.rdata = m_rsp.rdata;
      end
    end else begin
      sa_rsp.err = err_acc | m_rsp.err;
    end
  end

  // ======================================================================
  // FSM and counters
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= icb_bridge_pkg::RSP_IDLE;
      rsp_cnt <= '0;
      err_acc <= 1'b0;
    end else begin
      case (state)
        icb_bridge_pkg::RSP_IDLE: begin
          if (start) begin
            rsp_cnt <= '0;
            err_acc <= 1'b0;
            state   <= icb_bridge_pkg::RSP_MERGE;
          end
        end
        icb_bridge_pkg::RSP_MERGE: begin
          if (xfer) begin
            rsp_cnt <= rsp_cnt + 1'b1;
            err_acc <= err_acc | m_rsp.err;
            // rsp_idle rises one cycle after the final handoff
            if (last_rsp) state <= icb_bridge_pkg::RSP_IDLE;
          end
        end
        default: state <= icb_bridge_pkg::RSP_IDLE;
      endcase
    end
  end

  // raw word kept for the next merge
  always_ff @(posedge clk) begin
    if (xfer && cur_cmd.read) rbuf <= m_rsp.rdata;
  end

endmodule

// ==== icb_unalign_bridge.sv ====
/* top of the unaligned ICB bridge, upstream slave port to aligned downstream master
   connects the request FIFO, the command sequencer and the response merger */

`timescale 1ns/100ps
`include "icb_bridge_settings.svh"

module icb_unalign_bridge (
  input  logic                       clk,
  input  logic                       rst_n,
  // upstream request
  input  logic                       sa_cmd_valid,
  output logic                       sa_cmd_ready,
  input  icb_bridge_pkg::icb_cmd_t   sa_cmd,
  // upstream write data
  input  logic                       sa_w_valid,
  output logic                       sa_w_ready,
  input  icb_bridge_pkg::icb_wbeat_t sa_w,
  // upstream response
  output logic                       sa_rsp_valid,
  input  logic                       sa_rsp_ready,
  output icb_bridge_pkg::icb_rsp_t   sa_rsp,
  // downstream command
  output logic                       m_cmd_valid,
  input  logic                       m_cmd_ready,
  output icb_bridge_pkg::icb_mcmd_t  m_cmd,
  // downstream response
  input  logic                       m_rsp_valid,
  output logic                       m_rsp_ready,
  input  icb_bridge_pkg::icb_rsp_t   m_rsp
);

  // fifo head to sequencer
  icb_bridge_pkg::icb_cmd_t head;
  logic                     head_valid;
  logic                     pop;
  // sequencer to merger
  icb_bridge_pkg::icb_cmd_t cur_cmd;
  logic                     start;
  logic                     rsp_idle;

  icb_cmd_fifo fifo_i (
    .clk, .rst_n,
    .push_valid (sa_cmd_valid), .push_ready (sa_cmd_ready), .push_cmd (sa_cmd),
    .head, .head_valid, .pop
  );

  icb_cmd_sequencer seq_i (
    .clk, .rst_n,
    .head, .head_valid, .pop, .rsp_idle, .cur_cmd, .start,
    .sa_w_valid, .sa_w_ready, .sa_w,
    .m_cmd_valid, .m_cmd_ready, .m_cmd
  );

  icb_rsp_merger merge_i (
    .clk, .rst_n,
    .cur_cmd, .start, .rsp_idle,
    .m_rsp_valid, .m_rsp_ready, .m_rsp,
    .sa_rsp_valid, .sa_rsp_ready, .sa_rsp
  );

endmodule

// ==== icb_bridge_properties.sv ====
/* handshake properties on the bridge downstream command and upstream response ports
   bound into the top level by the bind statement at the end */

`timescale 1ns/100ps

module icb_bridge_properties (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      sa_cmd_valid,
  input logic                      sa_cmd_ready,
  input logic                      m_cmd_valid,
  input logic                      m_cmd_ready,
  input icb_bridge_pkg::icb_mcmd_t m_cmd,
  input logic                      sa_rsp_valid,
  input logic                      sa_rsp_ready,
  input icb_bridge_pkg::icb_rsp_t  sa_rsp
);

  // assertion failures so far
  int viol_cnt = 0;

  // set once the first upstream request is taken
  logic seen_cmd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_cmd <= 1'b0;
    end else if (sa_cmd_valid && sa_cmd_ready) begin
      seen_cmd <= 1'b1;
    end
  end

  // stalled command keeps valid and payload
  a_mcmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (m_cmd_valid && !m_cmd_ready) |=> (m_cmd_valid && $stable(m_cmd)))
    else begin
      viol_cnt++;
      $error("m_cmd dropped or changed before m_cmd_ready");
    end

  // stalled response keeps valid and payload
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (sa_rsp_valid && !sa_rsp_ready) |=> (sa_rsp_valid && $stable(sa_rsp)))
    else begin
      viol_cnt++;
      $error("sa_rsp dropped or changed before sa_rsp_ready");
    end

  // nothing leaves downstream out of reset until a request came in
  a_no_cmd_reset: assert property (@(posedge clk) disable iff (!rst_n)
    m_cmd_valid |-> seen_cmd)
    else begin
      viol_cnt++;
      $error("m_cmd_valid raised before any request was accepted");
    end

endmodule

bind icb_unalign_bridge icb_bridge_properties props_i (
  .clk, .rst_n,
  .sa_cmd_valid, .sa_cmd_ready,
  .m_cmd_valid, .m_cmd_ready, .m_cmd,
  .sa_rsp_valid, .sa_rsp_ready, .sa_rsp
);

// ==== icb_bridge_checker.sv ====
/* scoreboard for the bridge upstream ports, keeps a byte memory model and checks responses
   in request order, counts go back to the testbench top */

`timescale 1ns/100ps
`include "icb_bridge_settings.svh"

module icb_bridge_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       sa_cmd_valid,
  input  logic                       sa_cmd_ready,
  input  icb_bridge_pkg::icb_cmd_t   sa_cmd,
  input  logic                       sa_w_valid,
  input  logic                       sa_w_ready,
  input  icb_bridge_pkg::icb_wbeat_t sa_w,
  input  logic                       sa_rsp_valid,
  input  logic                       sa_rsp_ready,
  input  icb_bridge_pkg::icb_rsp_t   sa_rsp,
  output int                         err_cnt,
  output int                         done_cnt,
  output int                         rsp_cnt
);

  // byte image of the 64-word downstream memory
  logic [7:0]               bmem [256];
  // requests waiting for responses, writes waiting for data
  icb_bridge_pkg::icb_cmd_t req_q [$];
  icb_bridge_pkg::icb_cmd_t wr_q [$];
  int                       w_beat = 0;
  int                       r_beat = 0;
  int                       errs   = 0;
  int                       dones  = 0;
  int                       rsps   = 0;

  assign err_cnt  = errs;
  assign done_cnt = dones;
  assign rsp_cnt  = rsps;

  // same fill as the responder memory
  function automatic logic [31:0] fill_word(input int idx);
    return 32'h9e3779b9 * 32'(idx + 1);
  endfunction

  // any downstream beat on word 13 answers with err
  function automatic logic write_err(input icb_bridge_pkg::icb_cmd_t c);
    int first;
    int last;
    first = int'(c.addr) / 4;
    last  = (int'(c.addr) + 4 * (int'(c.len) + 1) - 1) / 4;
    return (first <= 13) && (last >= 13);
  endfunction

  initial begin
    int          i;
    logic [31:0] w;
    for (i = 0; i < 256; i++) begin
      w       = fill_word(i / 4);
      bmem[i] = w[8*(i%4) +: 8];
    end
  end

  // ======================================================================
  // upstream monitor, sampled mid-cycle
  // ======================================================================

  always @(negedge clk) begin
    icb_bridge_pkg::icb_cmd_t c;
    logic [31:0]              exp_data;
    logic                     exp_err;
    int                       a;
    int                       k;
    if (rst_n) begin
      if (sa_cmd_valid && sa_cmd_ready) begin
        req_q.push_back(sa_cmd);
        if (!sa_cmd.read) wr_q.push_back(sa_cmd);
      end
      // upstream beat i lands at addr plus 4*i, lane k at byte k
      if (sa_w_valid && sa_w_ready) begin
        if (wr_q.size() == 0) begin
          errs++;
          $display("write beat accepted while no write request was pending");
        end else begin
          c = wr_q[0];
          a = int'(c.addr) + 4 * w_beat;
          for (k = 0; k < 4; k++) begin
            if (sa_w.wmask[k]) bmem[(a + k) % 256] = sa_w.wdata[8*k +: 8];
          end
          if (w_beat == int'(c.len)) begin
            w_beat = 0;
            void'(wr_q.pop_front());
          end else begin
            w_beat++;
          end
        end
      end
      if (sa_rsp_valid && sa_rsp_ready) begin
        rsps++;
        if (req_q.size() == 0) begin
          errs++;
          $display("upstream response arrived with no request outstanding");
        end else begin
          c = req_q[0];
          if (c.read) begin
            a = int'(c.addr) + 4 * r_beat;
            for (k = 0; k < 4; k++) exp_data[8*k +: 8] = bmem[(a + k) % 256];
            // beat completes with the word holding its top byte
            exp_err = ((a + 3) / 4 == 13);
            if (sa_rsp.rdata !== exp_data) begin
              errs++;
              $display("Error: sa_rsp.rdata req %0d beat %0d expected %h actual %h",
                       dones, r_beat, exp_data, sa_rsp.rdata);
            end
          end else begin
            exp_err = write_err(c);
          end
          if (sa_rsp.err !== exp_err) begin
            errs++;
            $display("Error: sa_rsp.err req %0d beat %0d expected %h actual %h",
                     dones, r_beat, exp_err, sa_rsp.err);
          end
          // one reply per write, len+1 per read
          if (!c.read || r_beat == int'(c.len)) begin
            r_beat = 0;
            void'(req_q.pop_front());
            dones++;
          end else begin
            r_beat++;
          end
        end
      end
    end
  end

endmodule

// ==== tb_icb_unalign_bridge.sv ====
/* testbench for the unaligned ICB bridge, random traffic into a downstream memory responder
   runs five tests in sequence and prints one line per test plus a closing summary */

`timescale 1ns/100ps
`include "icb_bridge_settings.svh"

module tb_icb_unalign_bridge;

  localparam logic [31:0] SEED    = 32'hf5039957;
  localparam int          TIMEOUT = 20000;

  logic                       clk;
  logic                       rst_n;
  logic                       sa_cmd_valid;
  logic                       sa_cmd_ready;
  icb_bridge_pkg::icb_cmd_t   sa_cmd;
  logic                       sa_w_valid;
  logic                       sa_w_ready;
  icb_bridge_pkg::icb_wbeat_t sa_w;
  logic                       sa_rsp_valid;
  logic                       sa_rsp_ready;
  icb_bridge_pkg::icb_rsp_t   sa_rsp;
  logic                       m_cmd_valid;
  logic                       m_cmd_ready;
  icb_bridge_pkg::icb_mcmd_t  m_cmd;
  logic                       m_rsp_valid;
  logic                       m_rsp_ready;
  icb_bridge_pkg::icb_rsp_t   m_rsp;
  int                         chk_errs;
  int                         chk_done;
  int                         chk_rsps;

  // requests and write beats not yet taken by the DUT
  icb_bridge_pkg::icb_cmd_t   cmd_q [$];
  icb_bridge_pkg::icb_wbeat_t w_q [$];
  // downstream responder, word memory and replies in command order
  logic [31:0]                dmem [64];
  icb_bridge_pkg::icb_rsp_t   rsp_q [$];
  int                         rsp_delay;
  // transfers seen at the falling edge, acted on after the next rising edge
  logic                       cmd_go;
  logic                       w_go;
  logic                       rsp_go;
  logic [31:0]                rnd;
  int                         rsp_pct;
  int                         issued;
  int                         tb_fails;
  int                         tests;
  int                         errs_mark;

  icb_unalign_bridge dut_i (
    .clk, .rst_n,
    .sa_cmd_valid, .sa_cmd_ready, .sa_cmd,
    .sa_w_valid, .sa_w_ready, .sa_w,
    .sa_rsp_valid, .sa_rsp_ready, .sa_rsp,
    .m_cmd_valid, .m_cmd_ready, .m_cmd,
    .m_rsp_valid, .m_rsp_ready, .m_rsp
  );

  icb_bridge_checker chk_i (
    .clk, .rst_n,
    .sa_cmd_valid, .sa_cmd_ready, .sa_cmd,
    .sa_w_valid, .sa_w_ready, .sa_w,
    .sa_rsp_valid, .sa_rsp_ready, .sa_rsp,
    .err_cnt (chk_errs), .done_cnt (chk_done), .rsp_cnt (chk_rsps)
  );

  // ======================================================================
  // random source and helpers
  // ======================================================================

  // xorshift32, one shared stream
  function automatic logic [31:0] next_rand();
    rnd = rnd ^ (rnd << 13);
    rnd = rnd ^ (rnd >> 17);
    rnd = rnd ^ (rnd << 5);
    return rnd;
  endfunction

  function automatic logic chance(input int pct);
    return (next_rand() % 100) < pct;
  endfunction

  // distinct per word index
  function automatic logic [31:0] fill_word(input int idx);
    return 32'h9e3779b9 * 32'(idx + 1);
  endfunction

  // start below byte 224 so nine words still fit in 256 bytes
  function automatic logic [31:0] rand_addr(input logic aligned);
    logic [31:0] a;
    a      = next_rand() % 224;
    a[1:0] = 2'b00;
    if (!aligned) a = a + 1 + (next_rand() % 3);
    return a;
  endfunction

  task automatic add_req(input logic [31:0] addr, input logic rd, input int len,
                         input logic full_mask);
    icb_bridge_pkg::icb_cmd_t   c;
    icb_bridge_pkg::icb_wbeat_t w;
    logic [31:0]                r;
    int                         i;
    c.addr = addr;
    c.read = rd;
    c.len  = 3'(len);
    cmd_q.push_back(c);
    issued++;
    if (!rd) begin
      for (i = 0; i <= len; i++) begin
        w.wdata = next_rand();
        r       = next_rand();
        w.wmask = full_mask ? 4'hf : r[3:0];
        w_q.push_back(w);
      end
    end
  endtask

  // wait for every issued request to be answered
  task automatic finish_test(input string name);
    int cyc;
    cyc = 0;
    while (chk_done != issued && cyc < TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    tests++;
    if (chk_done != issued) begin
      tb_fails++;
      $display("test %0d %s: timed out with %0d of %0d requests answered",
               tests, name, chk_done, issued);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, chk_errs - errs_mark);
    end
    errs_mark = chk_errs;
  endtask

  // ======================================================================
  // clock, sampling and drive
  // ======================================================================

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    icb_bridge_pkg::icb_rsp_t r;
    int                       idx;
    int                       k;
    cmd_go = sa_cmd_valid && sa_cmd_ready;
    w_go   = sa_w_valid && sa_w_ready;
    rsp_go = m_rsp_valid && m_rsp_ready;
    if (rst_n && m_cmd_valid && m_cmd_ready) begin
      if (m_cmd.addr[1:0] != 2'b00 || m_cmd.addr > 32'd255) begin
        tb_fails++;
        $display("downstream command address %h is unaligned or outside the memory", m_cmd.addr);
      end
      idx     = int'(m_cmd.addr[7:2]);
      r.rdata = m_cmd.read ? dmem[idx] : '0;
      r.err   = (idx == 13);
      if (!m_cmd.read) begin
        for (k = 0; k < 4; k++) begin
          if (m_cmd.wmask[k]) dmem[idx][8*k +: 8] = m_cmd.wdata[8*k +: 8];
        end
      end
      rsp_q.push_back(r);
    end
  end

  // every input changes 1 ns after the rising edge
  always @(posedge clk) begin
    #1;
    if (cmd_go) begin
      void'(cmd_q.pop_front());
      sa_cmd_valid = 1'b0;
    end
    if (!sa_cmd_valid && cmd_q.size() > 0 && chance(70)) begin
      sa_cmd       = cmd_q[0];
      sa_cmd_valid = 1'b1;
    end
    if (w_go) begin
      void'(w_q.pop_front());
      sa_w_valid = 1'b0;
    end
    if (!sa_w_valid && w_q.size() > 0 && chance(70)) begin
      sa_w       = w_q[0];
      sa_w_valid = 1'b1;
    end
    // responder, one reply at a time after a short random gap
    if (rsp_go) begin
      void'(rsp_q.pop_front());
      m_rsp_valid = 1'b0;
      rsp_delay   = int'(next_rand() % 4);
    end
    if (!m_rsp_valid && rsp_q.size() > 0) begin
      if (rsp_delay > 0) begin
        rsp_delay--;
      end else begin
        m_rsp       = rsp_q[0];
        m_rsp_valid = 1'b1;
      end
    end
    m_cmd_ready  = chance(75);
    sa_rsp_ready = chance(rsp_pct);
  end

  // ======================================================================
  // test sequence
  // ======================================================================

  initial begin
    int          n;
    int          len;
    logic [31:0] a;
    logic [31:0] r;
    rst_n        = 1'b0;
    sa_cmd_valid = 1'b0;
    sa_cmd       = '0;
    sa_w_valid   = 1'b0;
    sa_w         = '0;
    sa_rsp_ready = 1'b0;
    m_cmd_ready  = 1'b0;
    m_rsp_valid  = 1'b0;
    m_rsp        = '0;
    cmd_go       = 1'b0;
    w_go         = 1'b0;
    rsp_go       = 1'b0;
    rnd          = SEED;
    rsp_pct      = 80;
    rsp_delay    = 0;
    issued       = 0;
    tb_fails     = 0;
    tests        = 0;
    errs_mark    = 0;
    for (n = 0; n < 64; n++) dmem[n] = fill_word(n);
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);

    // single beat first, then bursts, each read back
    for (n = 0; n < 6; n++) begin
      a   = rand_addr(1'b1);
      r   = next_rand();
      len = (n == 0) ? 0 : int'(r % 8);
      add_req(a, 1'b0, len, 1'b1);
      add_req(a, 1'b1, len, 1'b1);
    end
    finish_test("aligned write and readback");

    for (n = 0; n < 6; n++) begin
      a = rand_addr(1'b0);
      r = next_rand();
      add_req(a, 1'b0, int'(r % 8), 1'b0);
    end
    // full sweep catches bytes outside the masked span
    for (n = 0; n < 8; n++) add_req(32'(n * 32), 1'b1, 7, 1'b1);
    finish_test("unaligned masked writes");

    for (n = 0; n < 8; n++) begin
      a = rand_addr(1'b0);
      r = next_rand();
      add_req(a, 1'b1, int'(r % 8), 1'b1);
    end
    finish_test("unaligned burst reads");

    // word 13 holds bytes 52 to 55
    add_req(32'd50, 1'b1, 1, 1'b1);
    add_req(32'd53, 1'b0, 0, 1'b1);
    add_req(32'd44, 1'b0, 1, 1'b1);
    add_req(32'd52, 1'b1, 0, 1'b1);
    add_req(32'd40, 1'b0, 3, 1'b0);
    add_req(32'd41, 1'b1, 4, 1'b1);
    finish_test("error word responses");

    // slow upstream ready, queue well past the FIFO depth
    rsp_pct = 30;
    for (n = 0; n < 24; n++) begin
      r = next_rand();
      a = rand_addr(r[2:0] == 3'd0);
      add_req(a, r[3], int'(r[6:4]), r[7]);
    end
    finish_test("stress with back-pressure");
    rsp_pct = 80;

    $display("summary: %0d tests, %0d requests, %0d responses, %0d errors, %0d other failures",
             tests, issued, chk_rsps, chk_errs, tb_fails + dut_i.props_i.viol_cnt);
    if (chk_errs == 0 && tb_fails == 0 && dut_i.props_i.viol_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
icb_bridge_pkg.sv
icb_cmd_fifo.sv
icb_cmd_sequencer.sv
icb_rsp_merger.sv
icb_unalign_bridge.sv
icb_bridge_properties.sv
icb_bridge_checker.sv
tb_icb_unalign_bridge.sv

// ==== Makefile ====
# Verilator simulation of the unaligned ICB bridge
TOP := tb_icb_unalign_bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
